// File: cpuPkg.sv
// Shared types and codes for the multi-cycle MIPS-like core.
// Every RTL module imports this package, and so does the testbench.
`default_nettype none

package cpuPkg;

	typedef logic [31:0] word_t;
	typedef logic [8:0] memAdr_t;
	typedef logic [4:0] regAdr_t;
	typedef logic [2:0] aluCtl_t;
	typedef logic [1:0] branchCtl_t;

	localparam int MEM_DEPTH = 512;
	localparam int REG_COUNT = 32;

	// One instruction word, seen as register form or immediate/jump form
	typedef union packed {
		struct packed {
			logic [5:0] opcode;
			regAdr_t    rs;
			regAdr_t    rt;
			regAdr_t    rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} rForm;
		struct packed {
			logic [5:0]  opcode;
			regAdr_t     rs;
			regAdr_t     rt;
			logic [15:0] imm;
		} iForm;
	} instr_t;

	// Opcodes
	localparam logic [5:0] OP_REG  = 6'b000000;
	localparam logic [5:0] OP_LW   = 6'b100011;
	localparam logic [5:0] OP_SW   = 6'b101011;
	localparam logic [5:0] OP_J    = 6'b000010;
	localparam logic [5:0] OP_BNE  = 6'b000101;
	localparam logic [5:0] OP_ADDI = 6'b001000;

	// Funct codes of register instructions
	localparam logic [5:0] FN_ADD = 6'b100000;
	localparam logic [5:0] FN_SUB = 6'b100010;
	localparam logic [5:0] FN_AND = 6'b100100;
	localparam logic [5:0] FN_OR  = 6'b100101;
	localparam logic [5:0] FN_XOR = 6'b100110;
	localparam logic [5:0] FN_SLT = 6'b101010;
	localparam logic [5:0] FN_SLL = 6'b000000;
	localparam logic [5:0] FN_JR  = 6'b001000;

	localparam aluCtl_t ALU_NOP = 3'd0;
	localparam aluCtl_t ALU_ADD = 3'd1;
	localparam aluCtl_t ALU_SUB = 3'd2;
	localparam aluCtl_t ALU_AND = 3'd3;
	localparam aluCtl_t ALU_OR  = 3'd4;
	localparam aluCtl_t ALU_XOR = 3'd5;
	localparam aluCtl_t ALU_SLT = 3'd6;
	localparam aluCtl_t ALU_SLL = 3'd7;

	localparam branchCtl_t BR_NONE    = 2'd0;
	localparam branchCtl_t BR_BRANCH  = 2'd1;
	localparam branchCtl_t BR_JUMP    = 2'd2;
	localparam branchCtl_t BR_JUMPREG = 2'd3;

	// ALU B bus source and writeback source
	localparam logic B_REG   = 1'b0;
	localparam logic B_IMM   = 1'b1;
	localparam logic RES_ALU = 1'b0;
	localparam logic RES_MEM = 1'b1;

	// Core FSM states
	localparam logic [2:0] CS_FETCH = 3'd0;
	localparam logic [2:0] CS_EXEC  = 3'd1;
	localparam logic [2:0] CS_MEM   = 3'd2;
	localparam logic [2:0] CS_WB    = 3'd3;
	localparam logic [2:0] CS_HALT  = 3'd4;

	// Memory arbiter states and owners
	localparam logic [1:0] MS_IDLE    = 2'd0;
	localparam logic [1:0] MS_ACK     = 2'd1;
	localparam logic [1:0] MS_RELEASE = 2'd2;
	localparam logic [1:0] OWN_HOST   = 2'd0;
	localparam logic [1:0] OWN_DATA   = 2'd1;
	localparam logic [1:0] OWN_FETCH  = 2'd2;

endpackage

`default_nettype wire

// File: decode.sv
// Instruction decoder for the core; purely combinational.
// Turns the instruction register and the ALU zero flag into control signals.
`default_nettype none

module decode (
	input  cpuPkg::instr_t   instruction,
	input  logic             zFlag,
	output cpuPkg::regAdr_t  rfRdAdrx0,
	output cpuPkg::regAdr_t  rfRdAdrx1,
	output cpuPkg::regAdr_t  rfWrAdrx,
	output logic [15:0]      immediate,
	output cpuPkg::memAdr_t  pcDest,
	output logic [2:0]       aluCtl,
	output logic [1:0]       branchCtl,
	output logic             rfWriteEn,
	output logic             aluBusBSel,
	output logic             dmemResultSel,
	output logic             dmemRead,
	output logic             dmemWrite
);
	import cpuPkg::*;

	logic       useRd;
	logic [1:0] brBase;

	// Register view gives the three register fields, immediate view the rest
	assign rfRdAdrx0 = instruction.rForm.rs;
	assign rfRdAdrx1 = instruction.rForm.rt;
	assign rfWrAdrx  = useRd ? instruction.rForm.rd : instruction.iForm.rt;
	assign immediate = instruction.iForm.imm;
	assign pcDest    = instruction.iForm.imm[8:0];

	always_comb begin
		useRd         = 1'b0;
		rfWriteEn     = 1'b0;
		aluCtl        = ALU_NOP;
		aluBusBSel    = B_REG;
		dmemResultSel = RES_ALU;
		dmemRead      = 1'b0;
		dmemWrite     = 1'b0;
		brBase        = BR_NONE;
		case (instruction.rForm.opcode)
			OP_REG: begin
				useRd = 1'b1;
				case (instruction.rForm.funct)
					FN_ADD: aluCtl = ALU_ADD;
					FN_SUB: aluCtl = ALU_SUB;
					FN_AND: aluCtl = ALU_AND;
					FN_OR:  aluCtl = ALU_OR;
					FN_XOR: aluCtl = ALU_XOR;
					FN_SLT: aluCtl = ALU_SLT;
					FN_SLL: aluCtl = ALU_SLL;
					FN_JR:  brBase = BR_JUMPREG;
					default: aluCtl = ALU_NOP;
				endcase
				// Only real ALU ops write back, jr and unknown functs do not
				rfWriteEn = (aluCtl != ALU_NOP);
			end
			OP_LW: begin
				rfWriteEn     = 1'b1;
				aluCtl        = ALU_ADD;
				aluBusBSel    = B_IMM;
				dmemResultSel = RES_MEM;
				dmemRead      = 1'b1;
			end
			OP_SW: begin
				aluCtl     = ALU_ADD;
				aluBusBSel = B_IMM;
				dmemWrite  = 1'b1;
			end
			OP_ADDI: begin
				rfWriteEn  = 1'b1;
				aluCtl     = ALU_ADD;
				aluBusBSel = B_IMM;
			end
			OP_BNE: begin
				// Compare rs with rt
				aluCtl = ALU_SUB;
				brBase = BR_BRANCH;
			end
			OP_J: brBase = BR_JUMP;
			default: brBase = BR_NONE;
		endcase
	end

	// bne only branches when the registers differ
	assign branchCtl = (brBase == BR_BRANCH && zFlag) ? BR_NONE : brBase;

endmodule

`default_nettype wire

// File: regFile.sv
// Register file, 32 words, two asynchronous reads and one clocked write.
// Register 0 ignores writes and always reads zero.
`default_nettype none

module regFile (
	input  logic             clk,
	input  logic             arstN,
	input  cpuPkg::regAdr_t  rdAdr0,
	input  cpuPkg::regAdr_t  rdAdr1,
	input  cpuPkg::regAdr_t  wrAdr,
	input  cpuPkg::word_t    wrData,
	input  logic             wrEn,
	output cpuPkg::word_t    rdData0,
	output cpuPkg::word_t    rdData1
);
	import cpuPkg::*;

	word_t regs [REG_COUNT];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn && wrAdr != '0) begin
			regs[wrAdr] <= wrData;
		end
	end

	assign rdData0 = regs[rdAdr0];
	assign rdData1 = regs[rdAdr1];

endmodule

`default_nettype wire

// File: alu.sv
// Combinational ALU of the core with a zero flag.
// The NOP code still subtracts so that zFlag stays meaningful.
`default_nettype none

module alu (
	input  cpuPkg::word_t  a,
	input  cpuPkg::word_t  b,
	input  logic [2:0]     aluCtl,
	output cpuPkg::word_t  result,
	output logic           zFlag
);
	import cpuPkg::*;

	always_comb begin
		case (aluCtl)
			ALU_ADD: result = a + b;
			ALU_SUB: result = a - b;
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			ALU_XOR: result = a ^ b;
			// Signed compare, result is 1 or 0
			ALU_SLT: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			ALU_SLL: result = a << b[4:0];
			default: result = a - b;
		endcase
	end

	assign zFlag = (result == '0);

endmodule

`default_nettype wire

// File: arbitratedMem.sv
// Unified 512-word memory with host, data and fetch ports.
// Fixed priority host > data > fetch; every port uses a four-phase req/ack handshake.
`default_nettype none

module arbitratedMem (
	input  logic             clk,
	input  logic             arstN,
	input  logic             hostReq,
	input  logic             hostWe,
	input  cpuPkg::memAdr_t  hostAdr,
	input  cpuPkg::word_t    hostWData,
	output logic             hostAck,
	output cpuPkg::word_t    hostRData,
	input  logic             dataReq,
	input  logic             dataWe,
	input  cpuPkg::memAdr_t  dataAdr,
	input  cpuPkg::word_t    dataWData,
	output logic             dataAck,
	output cpuPkg::word_t    dataRData,
	input  logic             fetchReq,
	input  cpuPkg::memAdr_t  fetchAdr,
	output logic             fetchAck,
	output cpuPkg::word_t    fetchRData
);
	import cpuPkg::*;

	word_t      mem [MEM_DEPTH];
	logic [1:0] memState;
	logic [1:0] owner;
	logic       ownerReq;
	logic       grantHost, grantData, grantFetch;

	// Grants are only issued from idle
	assign grantHost  = (memState == MS_IDLE) && hostReq;
	assign grantData  = (memState == MS_IDLE) && !hostReq && dataReq;
	assign grantFetch = (memState == MS_IDLE) && !hostReq && !dataReq && fetchReq;

	always_comb begin
		case (owner)
			OWN_HOST: ownerReq = hostReq;
			OWN_DATA: ownerReq = dataReq;
			default:  ownerReq = fetchReq;
		endcase
	end

	// Access happens on the edge that closes the grant cycle
	always_ff @(posedge clk) begin
		if (grantHost) begin
			hostRData <= mem[hostAdr];
			if (hostWe) begin
				mem[hostAdr] <= hostWData;
			end
		end
		if (grantData) begin
			dataRData <= mem[dataAdr];
			if (dataWe) begin
				mem[dataAdr] <= dataWData;
			end
		end
		if (grantFetch) begin
			fetchRData <= mem[fetchAdr];
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			memState <= MS_IDLE;
			owner    <= OWN_HOST;
			hostAck  <= 1'b0;
			dataAck  <= 1'b0;
			fetchAck <= 1'b0;
		end else begin
			case (memState)
				MS_IDLE: begin
					if (grantHost) begin
						owner    <= OWN_HOST;
						hostAck  <= 1'b1;
						memState <= MS_ACK;
					end else if (grantData) begin
						owner    <= OWN_DATA;
						dataAck  <= 1'b1;
						memState <= MS_ACK;
					end else if (grantFetch) begin
						owner    <= OWN_FETCH;
						fetchAck <= 1'b1;
						memState <= MS_ACK;
					end
				end
				MS_ACK: begin
					// Hold ack until the owner lets go of req
					if (!ownerReq) begin
						hostAck  <= 1'b0;
						dataAck  <= 1'b0;
						fetchAck <= 1'b0;
						memState <= MS_RELEASE;
					end
				end
				default: memState <= MS_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: cpuCore.sv
// Multi-cycle core that runs FETCH, EXEC, optional MEM, then WB for each instruction.
// Masters the fetch and data ports of the shared memory; a self-jump halts it.
`default_nettype none

module cpuCore (
	input  logic             clk,
	input  logic             arstN,
	input  logic             run,
	output logic             fetchReq,
	output cpuPkg::memAdr_t  fetchAdr,
	input  logic             fetchAck,
	input  cpuPkg::word_t    fetchRData,
	output logic             dataReq,
	output logic             dataWe,
	output cpuPkg::memAdr_t  dataAdr,
	output cpuPkg::word_t    dataWData,
	input  logic             dataAck,
	input  cpuPkg::word_t    dataRData,
	output logic             halted,
	output logic             retired
);
	import cpuPkg::*;

	logic [2:0]  state;
	memAdr_t     pc, pcNext, pcDest;
	instr_t      ir;
	word_t       aluOut, aluResult, aluB, immExt, rdData0, rdData1, wbData;
	regAdr_t     rdAdr0, rdAdr1, wrAdr;
	logic [15:0] immediate;
	logic [2:0]  aluCtl;
	logic [1:0]  branchCtl;
	logic        rfWriteEn, aluBusBSel, dmemResultSel, dmemRead, dmemWrite, zFlag;
	logic        selfJump;

	decode u_decode (
		.instruction(ir), .zFlag(zFlag),
		.rfRdAdrx0(rdAdr0), .rfRdAdrx1(rdAdr1), .rfWrAdrx(wrAdr),
		.immediate(immediate), .pcDest(pcDest), .aluCtl(aluCtl), .branchCtl(branchCtl),
		.rfWriteEn(rfWriteEn), .aluBusBSel(aluBusBSel), .dmemResultSel(dmemResultSel),
		.dmemRead(dmemRead), .dmemWrite(dmemWrite)
	);

	regFile u_regFile (
		.clk(clk), .arstN(arstN),
		.rdAdr0(rdAdr0), .rdAdr1(rdAdr1), .wrAdr(wrAdr),
		.wrData(wbData), .wrEn(rfWriteEn && retired),
		.rdData0(rdData0), .rdData1(rdData1)
	);

	alu u_alu (
		.a(rdData0), .b(aluB), .aluCtl(aluCtl), .result(aluResult), .zFlag(zFlag)
	);

	assign immExt    = {{16{immediate[15]}}, immediate};
	assign aluB      = (aluBusBSel == B_IMM) ? immExt : rdData1;
	assign wbData    = (dmemResultSel == RES_MEM) ? dataRData : aluOut;
	assign fetchAdr  = pc;
	assign dataAdr   = aluOut[8:0];
	assign dataWData = rdData1;
	assign retired   = run && (state == CS_WB);
	assign selfJump  = (branchCtl == BR_JUMP) && (pcDest == pc);

	// IR and regs stay put until WB, so decode outputs are still valid there
	always_comb begin
		case (branchCtl)
			BR_BRANCH:  pcNext = pc + 9'd1 + immediate[8:0];
			BR_JUMP:    pcNext = pcDest;
			BR_JUMPREG: pcNext = rdData0[8:0];
			default:    pcNext = pc + 9'd1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (state == CS_FETCH && fetchReq && fetchAck) begin
			ir <= fetchRData;
		end
		if (state == CS_EXEC) begin
			aluOut <= aluResult;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state    <= CS_FETCH;
			pc       <= '0;
			fetchReq <= 1'b0;
			dataReq  <= 1'b0;
			dataWe   <= 1'b0;
			halted   <= 1'b0;
		end else if (!run) begin
			// Let an open handshake complete, then park at address 0
			if (fetchReq && fetchAck) begin
				fetchReq <= 1'b0;
			end
			if (dataReq && dataAck) begin
				dataReq <= 1'b0;
				dataWe  <= 1'b0;
			end
			if (!fetchReq && !dataReq) begin
				state  <= CS_FETCH;
				pc     <= '0;
				halted <= 1'b0;
			end
		end else begin
			case (state)
				CS_FETCH: begin
					if (!fetchReq && !fetchAck) begin
						fetchReq <= 1'b1;
					end else if (fetchReq && fetchAck) begin
						fetchReq <= 1'b0;
						state    <= CS_EXEC;
					end
				end
				CS_EXEC: state <= (dmemRead || dmemWrite) ? CS_MEM : CS_WB;
				CS_MEM: begin
					if (!dataReq && !dataAck) begin
						dataReq <= 1'b1;
						dataWe  <= dmemWrite;
					end else if (dataReq && dataAck) begin
						dataReq <= 1'b0;
						dataWe  <= 1'b0;
						state   <= CS_WB;
					end
				end
				CS_WB: begin
					pc <= pcNext;
					if (selfJump) begin
						halted <= 1'b1;
						state  <= CS_HALT;
					end else begin
						state <= CS_FETCH;
					end
				end
				// Stay halted until run drops
				default: state <= CS_HALT;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: cpuTop.sv
// Top level that joins the core and the shared memory and brings out the host port.
// The host loads programs and reads results while run is low or high.
`default_nettype none

module cpuTop (
	input  logic             clk,
	input  logic             arstN,
	input  logic             run,
	input  logic             hostReq,
	input  logic             hostWe,
	input  cpuPkg::memAdr_t  hostAdr,
	input  cpuPkg::word_t    hostWData,
	output logic             hostAck,
	output cpuPkg::word_t    hostRData,
	output logic             halted,
	output logic             retired
);
	import cpuPkg::*;

	logic    fetchReq, fetchAck;
	memAdr_t fetchAdr;
	word_t   fetchRData;
	logic    dataReq, dataWe, dataAck;
	memAdr_t dataAdr;
	word_t   dataWData, dataRData;

	cpuCore u_cpuCore (
		.clk(clk), .arstN(arstN), .run(run),
		.fetchReq(fetchReq), .fetchAdr(fetchAdr),
		.fetchAck(fetchAck), .fetchRData(fetchRData),
		.dataReq(dataReq), .dataWe(dataWe), .dataAdr(dataAdr),
		.dataWData(dataWData), .dataAck(dataAck), .dataRData(dataRData),
		.halted(halted), .retired(retired)
	);

	arbitratedMem u_arbitratedMem (
		.clk(clk), .arstN(arstN),
		.hostReq(hostReq), .hostWe(hostWe), .hostAdr(hostAdr),
		.hostWData(hostWData), .hostAck(hostAck), .hostRData(hostRData),
		.dataReq(dataReq), .dataWe(dataWe), .dataAdr(dataAdr),
		.dataWData(dataWData), .dataAck(dataAck), .dataRData(dataRData),
		.fetchReq(fetchReq), .fetchAdr(fetchAdr),
		.fetchAck(fetchAck), .fetchRData(fetchRData)
	);

endmodule

`default_nettype wire

// File: cpuTop_checker.sv
// Handshake assertions for the shared memory that bind attaches to arbitratedMem.
// They cover ack ownership, ack timing against req and the reset state.
`default_nettype none

module cpuTop_checker (
	input logic clk,
	input logic arstN,
	input logic hostReq,
	input logic hostAck,
	input logic dataReq,
	input logic dataAck,
	input logic fetchReq,
	input logic fetchAck
);
	timeunit 1ns;
	timeprecision 1ns;

	logic [2:0] reqs;
	logic [2:0] acks;
	int         failCount = 0;

	assign reqs = {hostReq, dataReq, fetchReq};
	assign acks = {hostAck, dataAck, fetchAck};

	// One owner at a time
	assert property (@(posedge clk) disable iff (!arstN) $onehot0(acks))
		else begin
			$error("more than one memory ack high");
			failCount++;
		end

	// A new ack needs a pending req
	assert property (@(posedge clk) disable iff (!arstN)
		(acks & ~$past(acks) & ~$past(reqs)) == 3'b000)
		else begin
			$error("memory ack rose without its req");
			failCount++;
		end

	// Ack holds while its req is still high
	assert property (@(posedge clk) disable iff (!arstN)
		($past(acks & reqs) & ~acks) == 3'b000)
		else begin
			$error("memory ack fell before its req");
			failCount++;
		end

	assert property (@(posedge clk) !arstN |-> acks == 3'b000)
		else begin
			$error("memory ack high during reset");
			failCount++;
		end

endmodule

bind arbitratedMem cpuTop_checker u_memChecker (
	.clk(clk),
	.arstN(arstN),
	.hostReq(hostReq),
	.hostAck(hostAck),
	.dataReq(dataReq),
	.dataAck(dataAck),
	.fetchReq(fetchReq),
	.fetchAck(fetchAck)
);

`default_nettype wire

// File: cpuTb.sv
// Directed testbench for cpuTop. It loads programs through the host port,
// runs them up to the self-jump and compares stored words with values computed here.
`default_nettype none

module cpuTb;
	timeunit 1ns;
	timeprecision 1ns;
	import cpuPkg::*;

	localparam int WAIT_LIMIT = 200;
	localparam int RUN_LIMIT  = 20000;

	logic    clk = 1'b0;
	logic    arstN, run, hostReq, hostWe, hostAck, halted, retired;
	memAdr_t hostAdr;
	word_t   hostWData, hostRData;

	int      errors = 0;
	int      checks = 0;
	int      testErrors = 0;
	int      retireCount = 0;
	int      retireBase = 0;
	word_t   lcgState = 32'd87486;
	instr_t  prog [$];

	cpuTop u_cpuTop (
		.clk(clk), .arstN(arstN), .run(run),
		.hostReq(hostReq), .hostWe(hostWe), .hostAdr(hostAdr),
		.hostWData(hostWData), .hostAck(hostAck), .hostRData(hostRData),
		.halted(halted), .retired(retired)
	);

	always #50 clk = ~clk;

	// Count WB cycles of the core
	always @(posedge clk) begin
		if (retired) begin
			retireCount <= retireCount + 1;
		end
	end

	function automatic word_t lcgNext();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic instr_t rInstr(logic [5:0] fn, regAdr_t rd, regAdr_t rs, regAdr_t rt);
		instr_t w;
		w.rForm.opcode = OP_REG;
		w.rForm.rs     = rs;
		w.rForm.rt     = rt;
		w.rForm.rd     = rd;
		w.rForm.shamt  = 5'd0;
		w.rForm.funct  = fn;
		return w;
	endfunction

	function automatic instr_t iInstr(logic [5:0] op, regAdr_t rs, regAdr_t rt, logic [15:0] imm);
		instr_t w;
		w.iForm.opcode = op;
		w.iForm.rs     = rs;
		w.iForm.rt     = rt;
		w.iForm.imm    = imm;
		return w;
	endfunction

	// A jump to its own address ends the program
	function automatic void appendHalt();
		prog.push_back(iInstr(OP_J, 5'd0, 5'd0, 16'(prog.size())));
	endfunction

	task automatic abortRun(input string what);
		$display("Timeout while waiting for %s", what);
		$display("FAIL: see errors above");
		$finish;
	endtask

	task automatic waitAck(input logic level);
		int n;
		n = 0;
		@(negedge clk);
		while (hostAck !== level && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (hostAck !== level) begin
			abortRun("the host ack");
		end
	endtask

	task automatic hostWrite(input memAdr_t adr, input word_t data);
		@(posedge clk);
		hostReq   <= 1'b1;
		hostWe    <= 1'b1;
		hostAdr   <= adr;
		hostWData <= data;
		waitAck(1'b1);
		@(posedge clk);
		hostReq <= 1'b0;
		hostWe  <= 1'b0;
		waitAck(1'b0);
	endtask

	task automatic hostRead(input memAdr_t adr, output word_t data);
		@(posedge clk);
		hostReq <= 1'b1;
		hostWe  <= 1'b0;
		hostAdr <= adr;
		waitAck(1'b1);
		data = hostRData;
		@(posedge clk);
		hostReq <= 1'b0;
		waitAck(1'b0);
	endtask

	task automatic loadProgram();
		foreach (prog[i]) begin
			hostWrite(memAdr_t'(i), prog[i]);
		end
	endtask

	// Drop run until halted clears, then restart the core from address 0
	task automatic startRun();
		int n;
		@(posedge clk);
		run <= 1'b0;
		n = 0;
		@(negedge clk);
		while (halted && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (halted) begin
			abortRun("halted to clear");
		end
		@(posedge clk);
		retireBase = retireCount;
		run <= 1'b1;
	endtask

	task automatic waitHalt();
		int n;
		n = 0;
		@(negedge clk);
		while (!halted && n < RUN_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (!halted) begin
			abortRun("halted");
		end
	endtask

	task automatic runUntilHalt();
		startRun();
		waitHalt();
	endtask

	task automatic checkWord(input string what, input word_t got, input word_t want);
		checks++;
		if (got !== want) begin
			errors++;
			testErrors++;
			$display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, want);
		end
	endtask

	task automatic checkFlag(input string what, input logic got, input logic want);
		checks++;
		if (got !== want) begin
			errors++;
			testErrors++;
			$display("FAILED at %0t ns: %s, got %b, expected %b", $time, what, got, want);
		end
	endtask

	task automatic expectWord(input memAdr_t adr, input word_t want, input string what);
		word_t got;
		hostRead(adr, got);
		checkWord(what, got, want);
	endtask

	task automatic reportTest(input string name);
		$display("Test %s finished with %0d errors", name, testErrors);
		testErrors = 0;
	endtask

	task automatic memRoundTrip();
		memAdr_t adrs [$];
		word_t   model [MEM_DEPTH];
		memAdr_t adr;
		word_t   data;
		for (int i = 0; i < 12; i++) begin
			adr  = memAdr_t'(lcgNext() >> 16);
			data = lcgNext();
			adrs.push_back(adr);
			model[adr] = data;
			hostWrite(adr, data);
		end
		// Overwrite the first address so that the later word wins
		data = lcgNext();
		model[adrs[0]] = data;
		hostWrite(adrs[0], data);
		foreach (adrs[i]) begin
			expectWord(adrs[i], model[adrs[i]], "host read back");
		end
		reportTest("host memory round trip");
	endtask

	task automatic registerArith();
		logic [5:0] fns [7];
		word_t      want [7];
		word_t      a, b;
		fns = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_XOR, FN_SLT, FN_SLL};
		for (int round = 0; round < 2; round++) begin
			a = lcgNext();
			b = lcgNext();
			want[0] = a + b;
			want[1] = a - b;
			want[2] = a & b;
			want[3] = a | b;
			want[4] = a ^ b;
			// With different signs the negative operand is the smaller one
			want[5] = (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
			want[6] = a * (32'd1 << b[4:0]);
			prog.delete();
			prog.push_back(iInstr(OP_LW, 5'd0, 5'd1, 16'h0100));
			prog.push_back(iInstr(OP_LW, 5'd0, 5'd2, 16'h0101));
			for (int k = 0; k < 7; k++) begin
				prog.push_back(rInstr(fns[k], 5'd3, 5'd1, 5'd2));
				prog.push_back(iInstr(OP_SW, 5'd0, 5'd3, 16'(16'h0110 + k)));
			end
			appendHalt();
			hostWrite(9'h100, a);
			hostWrite(9'h101, b);
			loadProgram();
			runUntilHalt();
			for (int k = 0; k < 7; k++) begin
				expectWord(memAdr_t'(9'h110 + k), want[k], "register op result");
			end
		end
		reportTest("register arithmetic");
	endtask

	task automatic immediateAndZero();
		word_t       v, sentinel;
		logic [15:0] negImm;
		v        = lcgNext();
		sentinel = lcgNext();
		negImm   = 16'hFFFF - 16'(lcgNext() % 32'd1000);
		prog.delete();
		prog.push_back(iInstr(OP_LW, 5'd0, 5'd4, 16'h0120));
		prog.push_back(iInstr(OP_ADDI, 5'd4, 5'd5, negImm));
		prog.push_back(iInstr(OP_ADDI, 5'd4, 5'd0, 16'h0077));
		prog.push_back(rInstr(FN_ADD, 5'd0, 5'd4, 5'd4));
		// Unknown opcode shaped like a store, then an unknown funct aimed at r4
		prog.push_back(iInstr(6'b111011, 5'd0, 5'd5, 16'h0124));
		prog.push_back(rInstr(6'b111111, 5'd4, 5'd5, 5'd5));
		prog.push_back(iInstr(OP_SW, 5'd0, 5'd0, 16'h0121));
		prog.push_back(iInstr(OP_SW, 5'd0, 5'd5, 16'h0122));
		prog.push_back(iInstr(OP_SW, 5'd0, 5'd4, 16'h0123));
		appendHalt();
		hostWrite(9'h120, v);
		hostWrite(9'h121, 32'hFFFF_FFFF);
		hostWrite(9'h124, sentinel);
		loadProgram();
		runUntilHalt();
		expectWord(9'h121, 32'd0, "register 0 after writes");
		expectWord(9'h122, v + {{16{negImm[15]}}, negImm}, "addi with negative immediate");
		expectWord(9'h123, v, "register after unknown funct");
		expectWord(9'h124, sentinel, "memory after unknown opcode");
		reportTest("immediate and register zero");
	endtask

	task automatic controlFlow();
		word_t count;
		count = (lcgNext() >> 16) % 32'd19 + 32'd1;
		prog.delete();
		prog.push_back(iInstr(OP_LW, 5'd0, 5'd1, 16'h0130));
		prog.push_back(iInstr(OP_ADDI, 5'd0, 5'd2, 16'h0000));
		prog.push_back(rInstr(FN_ADD, 5'd2, 5'd2, 5'd1));
		prog.push_back(iInstr(OP_ADDI, 5'd1, 5'd1, 16'hFFFF));
		prog.push_back(iInstr(OP_BNE, 5'd1, 5'd0, 16'hFFFD));
		prog.push_back(iInstr(OP_SW, 5'd0, 5'd2, 16'h0131));
		// Registers are equal here so this bne must not skip the marker
		prog.push_back(iInstr(OP_BNE, 5'd1, 5'd0, 16'h0001));
		prog.push_back(iInstr(OP_ADDI, 5'd0, 5'd6, 16'h005A));
		prog.push_back(iInstr(OP_ADDI, 5'd0, 5'd7, 16'd12));
		prog.push_back(rInstr(FN_JR, 5'd0, 5'd7, 5'd0));
		prog.push_back(iInstr(OP_ADDI, 5'd6, 5'd6, 16'h0100));
		prog.push_back(iInstr(OP_ADDI, 5'd6, 5'd6, 16'h0200));
		prog.push_back(iInstr(OP_ADDI, 5'd6, 5'd6, 16'h0033));
		prog.push_back(iInstr(OP_SW, 5'd0, 5'd6, 16'h0132));
		appendHalt();
		hostWrite(9'h130, count);
		loadProgram();
		runUntilHalt();
		checkWord("instructions retired up to the self-jump",
			word_t'(retireCount - retireBase), 32'd3 * count + 32'd10);
		expectWord(9'h131, count * (count + 32'd1) / 32'd2, "loop sum");
		expectWord(9'h132, 32'h5A + 32'h33, "jr routine marker");
		checkFlag("halted held after the self-jump", halted, 1'b1);
		reportTest("control flow");
	endtask

	task automatic hostDuringRun();
		word_t m, quiet, got;
		int    n;
		m     = 32'd200 + (lcgNext() >> 16) % 32'd50;
		quiet = lcgNext();
		prog.delete();
		prog.push_back(iInstr(OP_LW, 5'd0, 5'd1, 16'h0140));
		prog.push_back(iInstr(OP_ADDI, 5'd0, 5'd2, 16'h0000));
		prog.push_back(iInstr(OP_ADDI, 5'd2, 5'd2, 16'h0003));
		prog.push_back(iInstr(OP_ADDI, 5'd1, 5'd1, 16'hFFFF));
		prog.push_back(iInstr(OP_BNE, 5'd1, 5'd0, 16'hFFFD));
		prog.push_back(iInstr(OP_SW, 5'd0, 5'd2, 16'h0141));
		appendHalt();
		hostWrite(9'h140, m);
		hostWrite(9'h150, quiet);
		loadProgram();
		startRun();
		n = 0;
		@(negedge clk);
		while (retireCount - retireBase < 10 && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (retireCount - retireBase < 10) begin
			abortRun("the first retired instructions");
		end
		hostRead(9'h150, got);
		checkWord("host read while running", got, quiet);
		checkFlag("core still running after host read", halted, 1'b0);
		waitHalt();
		checkWord("retired pulses before halt", word_t'(retireCount - retireBase),
			32'd3 * m + 32'd4);
		expectWord(9'h141, 32'd3 * m, "long loop result");
		reportTest("host access during execution");
	endtask

	initial begin
		arstN     <= 1'b0;
		run       <= 1'b0;
		hostReq   <= 1'b0;
		hostWe    <= 1'b0;
		hostAdr   <= '0;
		hostWData <= '0;
		repeat (5) @(posedge clk);
		arstN <= 1'b1;
		memRoundTrip();
		registerArith();
		immediateAndZero();
		controlFlow();
		hostDuringRun();
		if (u_cpuTop.u_arbitratedMem.u_memChecker.failCount != 0) begin
			errors++;
			$display("Memory handshake assertions failed %0d times",
				u_cpuTop.u_arbitratedMem.u_memChecker.failCount);
		end
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
cpuPkg.sv
decode.sv
regFile.sv
alu.sv
arbitratedMem.sv
cpuCore.sv
cpuTop.sv
cpuTop_checker.sv
cpuTb.sv

// File: run.sh
#!/bin/sh
# Builds the core testbench with Verilator, runs it and checks the log for the pass message

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ns --top-module cpuTb \
	-f tb.f -o cpuTbSim > build.log 2>&1; then
	cat build.log
	echo "Verilator build failed"
	exit 1
fi

if ! ./obj_dir/cpuTbSim +verilator+error+limit+100 > sim.log 2>&1; then
	cat sim.log
	echo "Simulation exited with an error status"
	exit 1
fi

cat sim.log
if grep -qx "PASS: all tests" sim.log; then
	exit 0
fi
exit 1
